/* filelist.f */
rtl/rvga_pkg.sv
rtl/decode_stage.sv
rtl/reg_file.sv
rtl/rfetch_stage.sv
rtl/execute_stage.sv
rtl/rvga_core.sv
tests/rvga_core_checker.sv
tests/rvga_core_sva.sv
tests/tb_rvga_core.sv

/* tests/tb_rvga_core.sv */
`timescale 1ns/1ns

module tb_rvga_core;

  typedef struct packed {
    rvga_pkg::rvga_word inst;
    rvga_pkg::rvga_reg  rd;
    rvga_pkg::rvga_word data;
    logic               illegal;
    int                 gap;      // Idle cycles before the row, negative draws a random gap
  } test_row_t;

  logic                   clk;
  logic                   arst_n;
  logic                   inst_valid;
  rvga_pkg::rvga_word     inst;
  rvga_pkg::rvga_result_t result;

  test_row_t   rows[$];
  logic [31:0] lfsr_state;
  int          wait_cycles;
  logic        drain_timeout;

  rvga_core uut (
    .clk        (clk),
    .arst_n     (arst_n),
    .inst_valid (inst_valid),
    .inst       (inst),
    .result     (result)
  );

  rvga_core_checker chk (
    .clk    (clk),
    .arst_n (arst_n),
    .result (result)
  );

  always #2 clk = ~clk;

  // ==============================
  // Instruction encoders
  // ==============================
  function automatic rvga_pkg::rvga_word imm_inst(input logic [11:0] imm,
      input rvga_pkg::rvga_reg rs1, input logic [2:0] f3, input rvga_pkg::rvga_reg rd);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic rvga_pkg::rvga_word reg_inst(input logic [6:0] f7,
      input rvga_pkg::rvga_reg rs2, input rvga_pkg::rvga_reg rs1, input logic [2:0] f3,
      input rvga_pkg::rvga_reg rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic rvga_pkg::rvga_word upper_inst(input logic [19:0] imm,
      input rvga_pkg::rvga_reg rd);
    return {imm, rd, 7'b0110111};
  endfunction

  // Galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
  endfunction

  task automatic draw_gap(output int gap);
    gap = 0;
    for (int b = 0; b < 2; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      gap = gap + (int'(lfsr_state[0]) << b);
    end
  endtask

  task automatic add_row(input rvga_pkg::rvga_word word, input rvga_pkg::rvga_reg rd,
      input rvga_pkg::rvga_word data, input logic illegal, input int gap);
    test_row_t row;
    row.inst    = word;
    row.rd      = rd;
    row.data    = data;
    row.illegal = illegal;
    row.gap     = gap;
    rows.push_back(row);
  endtask

  // ==============================
  // Stimulus table
  // ==============================
  task automatic load_table();
    add_row(imm_inst(12'h005, 5'd0, 3'd0, 5'd1), 5'd1, 32'h0000_0005, 1'b0, -1);
    add_row(imm_inst(12'hFFD, 5'd0, 3'd0, 5'd2), 5'd2, 32'hFFFF_FFFD, 1'b0, -1);
    add_row(imm_inst(12'h001, 5'd2, 3'd2, 5'd3), 5'd3, 32'h0000_0001, 1'b0, -1);
    add_row(imm_inst(12'h001, 5'd2, 3'd3, 5'd4), 5'd4, 32'h0000_0000, 1'b0, -1);
    add_row(imm_inst(12'hFFF, 5'd1, 3'd3, 5'd5), 5'd5, 32'h0000_0001, 1'b0, -1);
    add_row(imm_inst(12'hFFE, 5'd2, 3'd2, 5'd29), 5'd29, 32'h0000_0001, 1'b0, -1);
    add_row(imm_inst(12'h0F0, 5'd1, 3'd4, 5'd6), 5'd6, 32'h0000_00F5, 1'b0, -1);
    add_row(imm_inst(12'h700, 5'd1, 3'd6, 5'd7), 5'd7, 32'h0000_0705, 1'b0, -1);
    add_row(imm_inst(12'h0FF, 5'd2, 3'd7, 5'd8), 5'd8, 32'h0000_00FD, 1'b0, -1);
    add_row(imm_inst(12'h004, 5'd1, 3'd1, 5'd9), 5'd9, 32'h0000_0050, 1'b0, -1);
    add_row(imm_inst(12'h01C, 5'd2, 3'd5, 5'd10), 5'd10, 32'h0000_000F, 1'b0, -1);
    add_row(imm_inst(12'h401, 5'd2, 3'd5, 5'd11), 5'd11, 32'hFFFF_FFFE, 1'b0, -1);
    add_row(reg_inst(7'h00, 5'd2, 5'd1, 3'd0, 5'd12), 5'd12, 32'h0000_0002, 1'b0, -1);
    add_row(reg_inst(7'h20, 5'd2, 5'd1, 3'd0, 5'd13), 5'd13, 32'h0000_0008, 1'b0, -1);
    add_row(reg_inst(7'h00, 5'd1, 5'd1, 3'd1, 5'd14), 5'd14, 32'h0000_00A0, 1'b0, -1);
    add_row(reg_inst(7'h00, 5'd1, 5'd2, 3'd2, 5'd15), 5'd15, 32'h0000_0001, 1'b0, -1);
    add_row(reg_inst(7'h00, 5'd1, 5'd2, 3'd3, 5'd16), 5'd16, 32'h0000_0000, 1'b0, -1);
    add_row(reg_inst(7'h00, 5'd7, 5'd6, 3'd4, 5'd17), 5'd17, 32'h0000_07F0, 1'b0, -1);
    add_row(reg_inst(7'h00, 5'd3, 5'd2, 3'd5, 5'd18), 5'd18, 32'h7FFF_FFFE, 1'b0, -1);
    add_row(reg_inst(7'h20, 5'd3, 5'd2, 3'd5, 5'd19), 5'd19, 32'hFFFF_FFFE, 1'b0, -1);
    add_row(reg_inst(7'h00, 5'd7, 5'd6, 3'd6, 5'd20), 5'd20, 32'h0000_07F5, 1'b0, -1);
    add_row(reg_inst(7'h00, 5'd8, 5'd7, 3'd7, 5'd21), 5'd21, 32'h0000_0005, 1'b0, -1);
    // Constant build, then dependent chains with no gap and a one-cycle gap
    add_row(upper_inst(20'h12345, 5'd22), 5'd22, 32'h1234_5000, 1'b0, -1);
    add_row(imm_inst(12'h678, 5'd22, 3'd0, 5'd22), 5'd22, 32'h1234_5678, 1'b0, 0);
    add_row(imm_inst(12'h001, 5'd22, 3'd0, 5'd23), 5'd23, 32'h1234_5679, 1'b0, 1);
    add_row(reg_inst(7'h00, 5'd23, 5'd23, 3'd0, 5'd24), 5'd24, 32'h2468_ACF2, 1'b0, 0);
    add_row(imm_inst(12'h001, 5'd22, 3'd0, 5'd28), 5'd28, 32'h1234_5679, 1'b0, 3);
    // x0 as a destination, then read straight away
    add_row(imm_inst(12'h007, 5'd1, 3'd0, 5'd0), 5'd0, 32'h0000_000C, 1'b0, -1);
    add_row(reg_inst(7'h00, 5'd1, 5'd0, 3'd0, 5'd25), 5'd25, 32'h0000_0005, 1'b0, 0);
    // A branch into x5 and a load into x6 must leave both registers alone
    add_row({7'd0, 5'd1, 5'd1, 3'd0, 5'd5, 7'b1100011}, 5'd5, 32'h0, 1'b1, -1);
    add_row({12'd0, 5'd1, 3'b010, 5'd6, 7'b0000011}, 5'd6, 32'h0, 1'b1, 0);
    add_row(imm_inst(12'h000, 5'd5, 3'd0, 5'd26), 5'd26, 32'h0000_0001, 1'b0, 0);
    add_row(imm_inst(12'h000, 5'd6, 3'd0, 5'd27), 5'd27, 32'h0000_00F5, 1'b0, -1);
    add_row(rvga_pkg::RVGA_NOP, 5'd0, 32'h0, 1'b0, -1);
  endtask

  task automatic send_inst(input rvga_pkg::rvga_word word);
    inst_valid = 1'b1;
    inst       = word;
    @(negedge clk);
    inst_valid = 1'b0;
    inst       = rvga_pkg::RVGA_NOP;
  endtask

  // ==============================
  // Main sequence
  // ==============================
  initial begin
    int gap;
    int failures;
    clk           = 1'b0;
    arst_n        = 1'b0;
    inst_valid    = 1'b0;
    inst          = rvga_pkg::RVGA_NOP;
    lfsr_state    = 32'd83159;
    drain_timeout = 1'b0;
    load_table();

    repeat (8) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);

    foreach (rows[i]) begin
      if (rows[i].gap < 0) begin
        draw_gap(gap);
      end else begin
        gap = rows[i].gap;
      end
      repeat (gap) @(negedge clk);
      chk.push_expected(rows[i].rd, rows[i].data, rows[i].illegal);
      send_inst(rows[i].inst);
    end

    wait_cycles = 0;
    while (chk.pending() != 0 && wait_cycles < 50) begin
      @(negedge clk);
      wait_cycles++;
    end
    if (chk.pending() != 0) begin
      $display("Timeout: %0d instructions never produced a result", chk.pending());
      drain_timeout = 1'b1;
    end

    failures = chk.fail_count + uut.sva.fail_count + (drain_timeout ? 1 : 0);
    $display("Summary: %0d passed, %0d failed", chk.pass_count, failures);
    if (failures == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* tests/rvga_core_sva.sv */
`timescale 1ns/1ns

module rvga_core_sva (
  input logic                   clk,
  input logic                   arst_n,
  input logic                   inst_valid,
  input rvga_pkg::rvga_result_t result
);

  int fail_count = 0;

  // ==============================
  // Handshake timing
  // ==============================
  assert property (@(posedge clk) disable iff (!arst_n)
    result.valid == $past(inst_valid, 3))
    else begin
      $error("result.valid does not follow inst_valid by three cycles");
      fail_count++;
    end

  assert property (@(posedge clk) !arst_n |-> !result.valid)
    else begin
      $error("result.valid high during reset");
      fail_count++;
    end

  // Rejected instructions carry no data
  assert property (@(posedge clk) disable iff (!arst_n)
    (result.valid && result.illegal) |-> (result.data == '0))
    else begin
      $error("illegal result with nonzero data");
      fail_count++;
    end

endmodule

bind rvga_core rvga_core_sva sva (
  .clk        (clk),
  .arst_n     (arst_n),
  .inst_valid (inst_valid),
  .result     (result)
);

/* tests/rvga_core_checker.sv */
`timescale 1ns/1ns

module rvga_core_checker (
  input logic                   clk,
  input logic                   arst_n,
  input rvga_pkg::rvga_result_t result
);

  typedef struct packed {
    rvga_pkg::rvga_reg  rd;
    rvga_pkg::rvga_word data;
    logic               illegal;
  } expect_t;

  expect_t expected[$];
  int      test_num   = 0;
  int      pass_count = 0;
  int      fail_count = 0;

  function automatic int pending();
    return expected.size();
  endfunction

  task automatic push_expected(input rvga_pkg::rvga_reg rd, input rvga_pkg::rvga_word data,
      input logic illegal);
    expect_t entry;
    entry.rd      = rd;
    entry.data    = data;
    entry.illegal = illegal;
    expected.push_back(entry);
  endtask

  function automatic logic field_matches(input string name, input logic [31:0] exp_val,
      input logic [31:0] act_val);
    if (exp_val !== act_val) begin
      $display("ERR t=%0t %s expected 0x%08h got 0x%08h", $time, name, exp_val, act_val);
      return 1'b0;
    end
    return 1'b1;
  endfunction

  // Outputs settle after the rising edge, so they are read on the falling one
  always @(negedge clk) begin
    expect_t head;
    logic    ok;
    if (arst_n && result.valid) begin
      test_num++;
      if (expected.size() == 0) begin
        $display("Test %0d failed: result strobe at %0t with no instruction outstanding",
                 test_num, $time);
        fail_count++;
      end else begin
        head = expected.pop_front();
        ok = field_matches("result.rd", 32'(head.rd), 32'(result.rd));
        ok = field_matches("result.illegal", 32'(head.illegal), 32'(result.illegal)) && ok;
        ok = field_matches("result.data", head.data, result.data) && ok;
        if (ok) begin
          pass_count++;
          $display("Test %0d ok: rd=x%0d data=0x%08h illegal=%0b",
                   test_num, result.rd, result.data, result.illegal);
        end else begin
          fail_count++;
          $display("Test %0d failed", test_num);
        end
      end
    end
  end

endmodule

/* rtl/rvga_core.sv */
`timescale 1ns/1ns

module rvga_core (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   inst_valid,
  input  rvga_pkg::rvga_word     inst,
  output rvga_pkg::rvga_result_t result
);

  rvga_pkg::rvga_decoded_t  decoded;
  rvga_pkg::rvga_operands_t operands;
  rvga_pkg::rvga_wb_t       wb;
  rvga_pkg::rvga_reg        rs1;
  rvga_pkg::rvga_reg        rs2;
  rvga_pkg::rvga_word       rdata1;
  rvga_pkg::rvga_word       rdata2;

  // ==============================
  // Pipeline
  // ==============================
  decode_stage u_decode (
    .clk        (clk),
    .arst_n     (arst_n),
    .inst_valid (inst_valid),
    .inst       (inst),
    .decoded    (decoded)
  );

  rfetch_stage u_rfetch (
    .clk      (clk),
    .arst_n   (arst_n),
    .decoded  (decoded),
    .rs1      (rs1),
    .rs2      (rs2),
    .rdata1   (rdata1),
    .rdata2   (rdata2),
    .wb       (wb),
    .operands (operands)
  );

  // Architectural state, read by rfetch and written by execute
  reg_file u_reg_file (
    .clk    (clk),
    .arst_n (arst_n),
    .rs1    (rs1),
    .rs2    (rs2),
    .rdata1 (rdata1),
    .rdata2 (rdata2),
    .wb     (wb)
  );

  execute_stage u_execute (
    .clk      (clk),
    .arst_n   (arst_n),
    .operands (operands),
    .wb       (wb),
    .result   (result)
  );

endmodule

/* rtl/execute_stage.sv */
`timescale 1ns/1ns

module execute_stage (
  input  logic                     clk,
  input  logic                     arst_n,
  input  rvga_pkg::rvga_operands_t operands,
  output rvga_pkg::rvga_wb_t       wb,
  output rvga_pkg::rvga_result_t   result
);

  rvga_pkg::rvga_word     alu_res;
  rvga_pkg::rvga_word     res_data;
  logic [4:0]             shamt;
  rvga_pkg::rvga_result_t res_q;
  logic                   valid_q;

  assign shamt = operands.op_b[4:0];

  // ==============================
  // ALU
  // ==============================
  always_comb begin
    case (operands.funct3)
      rvga_pkg::RVGA_F3_ADD: begin
        // Bit 30 of addi is part of the immediate, so only R format subtracts
        if (operands.alt && !operands.use_imm) begin
          alu_res = operands.op_a - operands.op_b;
        end else begin
          alu_res = operands.op_a + operands.op_b;
        end
      end
      rvga_pkg::RVGA_F3_SLL:  alu_res = operands.op_a << shamt;
      rvga_pkg::RVGA_F3_SLT:  alu_res = rvga_pkg::rvga_word'($signed(operands.op_a) <
                                                             $signed(operands.op_b));
      rvga_pkg::RVGA_F3_SLTU: alu_res = rvga_pkg::rvga_word'(operands.op_a < operands.op_b);
      rvga_pkg::RVGA_F3_XOR:  alu_res = operands.op_a ^ operands.op_b;
      rvga_pkg::RVGA_F3_SR: begin
        if (operands.alt) begin
          alu_res = $signed(operands.op_a) >>> shamt;  // sra and srai
        end else begin
          alu_res = operands.op_a >> shamt;
        end
      end
      rvga_pkg::RVGA_F3_OR:   alu_res = operands.op_a | operands.op_b;
      default:                alu_res = operands.op_a & operands.op_b;
    endcase

    // The funct3 slot of LUI holds immediate bits
    if (operands.opcode == rvga_pkg::e_rvga_opcode_lui) begin
      alu_res = operands.op_b;
    end
  end

  assign res_data = operands.illegal ? '0 : alu_res;

  // Write-back request, also seen by rfetch for forwarding
  assign wb.we   = operands.valid && !operands.illegal;
  assign wb.rd   = operands.rd;
  assign wb.data = res_data;

  // ==============================
  // Result register
  // ==============================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= operands.valid;
    end
  end

  always_ff @(posedge clk) begin
    res_q.valid   <= operands.valid;
    res_q.illegal <= operands.illegal;
    res_q.rd      <= operands.rd;
    res_q.data    <= res_data;
  end

  always_comb begin
    result         = res_q;
    result.valid   = valid_q;
  end

endmodule

/* rtl/rfetch_stage.sv */
`timescale 1ns/1ns

module rfetch_stage (
  input  logic                     clk,
  input  logic                     arst_n,
  input  rvga_pkg::rvga_decoded_t  decoded,
  output rvga_pkg::rvga_reg        rs1,
  output rvga_pkg::rvga_reg        rs2,
  input  rvga_pkg::rvga_word       rdata1,
  input  rvga_pkg::rvga_word       rdata2,
  input  rvga_pkg::rvga_wb_t       wb,
  output rvga_pkg::rvga_operands_t operands
);

  logic                     fwd1;
  logic                     fwd2;
  rvga_pkg::rvga_word       src1;
  rvga_pkg::rvga_word       src2;
  rvga_pkg::rvga_operands_t ops_next;
  rvga_pkg::rvga_operands_t ops_q;
  logic                     valid_q;

  assign rs1 = decoded.rs1;
  assign rs2 = decoded.rs2;

  // The instruction in execute has not been written back yet
  assign fwd1 = wb.we && (wb.rd != '0) && (wb.rd == decoded.rs1);
  assign fwd2 = wb.we && (wb.rd != '0) && (wb.rd == decoded.rs2);

  assign src1 = fwd1 ? wb.data : rdata1;
  assign src2 = fwd2 ? wb.data : rdata2;

  always_comb begin
    ops_next.valid   = decoded.valid;
    ops_next.illegal = decoded.illegal;
    ops_next.opcode  = decoded.opcode;
    ops_next.funct3  = decoded.funct3;
    ops_next.alt     = decoded.alt;
    ops_next.rd      = decoded.rd;
    ops_next.use_imm = (decoded.inst_type != rvga_pkg::e_rvga_inst_type_r);
    // LUI adds its immediate to zero
    ops_next.op_a    = (decoded.inst_type == rvga_pkg::e_rvga_inst_type_u) ? '0 : src1;
    ops_next.op_b    = ops_next.use_imm ? decoded.imm : src2;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= ops_next.valid;
    end
  end

  always_ff @(posedge clk) begin
    ops_q <= ops_next;
  end

  always_comb begin
    operands       = ops_q;
    operands.valid = valid_q;
  end

endmodule

/* rtl/reg_file.sv */
`timescale 1ns/1ns

module reg_file (
  input  logic               clk,
  input  logic               arst_n,
  input  rvga_pkg::rvga_reg  rs1,
  input  rvga_pkg::rvga_reg  rs2,
  output rvga_pkg::rvga_word rdata1,
  output rvga_pkg::rvga_word rdata2,
  input  rvga_pkg::rvga_wb_t wb
);

  rvga_pkg::rvga_word regs [rvga_pkg::RVGA_NUM_REGS];

  logic wr_en;

  // x0 is never written, so it keeps its reset value of zero
  assign wr_en = wb.we && (wb.rd != '0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < rvga_pkg::RVGA_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // Same-cycle writes are not visible here
  // Execute results reach a dependent instruction through rfetch forwarding
  assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* rtl/decode_stage.sv */
`timescale 1ns/1ns

module decode_stage (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    inst_valid,
  input  rvga_pkg::rvga_word      inst,
  output rvga_pkg::rvga_decoded_t decoded
);

  rvga_pkg::rvga_decoded_t dec_next;
  rvga_pkg::rvga_decoded_t dec_q;
  logic                    valid_q;

  // ==============================
  // Field split and classification
  // ==============================
  always_comb begin
    dec_next.valid   = inst_valid;
    dec_next.opcode  = rvga_pkg::rvga_opcode_e'(inst[6:0]);
    dec_next.funct3  = inst[14:12];
    dec_next.alt     = inst[30];
    dec_next.rs1     = inst[19:15];
    dec_next.rs2     = inst[24:20];
    dec_next.rd      = inst[11:7];
    dec_next.illegal = 1'b0;

    case (dec_next.opcode)
      rvga_pkg::e_rvga_opcode_op: begin
        dec_next.inst_type = rvga_pkg::e_rvga_inst_type_r;
        dec_next.imm       = '0;
      end
      rvga_pkg::e_rvga_opcode_imm: begin
        dec_next.inst_type = rvga_pkg::e_rvga_inst_type_i;
        dec_next.imm       = {{20{inst[31]}}, inst[31:20]};  // Sign-extended I immediate
      end
      rvga_pkg::e_rvga_opcode_lui: begin
        dec_next.inst_type = rvga_pkg::e_rvga_inst_type_u;
        dec_next.imm       = {inst[31:12], 12'b0};
      end
      rvga_pkg::e_rvga_opcode_br: begin
        // No PC in this core, so branches cannot execute
        dec_next.inst_type = rvga_pkg::e_rvga_inst_type_r;
        dec_next.imm       = '0;
        dec_next.illegal   = 1'b1;
      end
      default: begin
        dec_next.inst_type = rvga_pkg::e_rvga_inst_type_r;
        dec_next.imm       = '0;
        dec_next.illegal   = 1'b1;
      end
    endcase
  end

  // ==============================
  // Stage register
  // ==============================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= dec_next.valid;
    end
  end

  always_ff @(posedge clk) begin
    dec_q <= dec_next;
  end

  always_comb begin
    decoded       = dec_q;
    decoded.valid = valid_q;  // Only the strobe bit is under reset
  end

endmodule

/* rtl/rvga_pkg.sv */
package rvga_pkg;

  // ==============================
  // Widths
  // ==============================
  localparam int RVGA_XLEN     = 32;
  localparam int RVGA_REG_BITS = 5;
  localparam int RVGA_NUM_REGS = 32;

  typedef logic [RVGA_XLEN-1:0]     rvga_word;
  typedef logic [RVGA_REG_BITS-1:0] rvga_reg;
  typedef logic [2:0]               rvga_funct3;

  // ==============================
  // Encodings
  // ==============================
  typedef enum logic [6:0] {
    e_rvga_opcode_op  = 7'b0110011,
    e_rvga_opcode_imm = 7'b0010011,
    e_rvga_opcode_lui = 7'b0110111,
    e_rvga_opcode_br  = 7'b1100011  // Recognised only to be rejected
  } rvga_opcode_e;

  typedef enum logic [2:0] {
    e_rvga_inst_type_r = 3'd0,
    e_rvga_inst_type_i = 3'd1,
    e_rvga_inst_type_u = 3'd2
  } rvga_inst_type_e;

  // ALU function codes, as carried in funct3
  localparam rvga_funct3 RVGA_F3_ADD  = 3'b000;  // add, sub, addi
  localparam rvga_funct3 RVGA_F3_SLL  = 3'b001;
  localparam rvga_funct3 RVGA_F3_SLT  = 3'b010;
  localparam rvga_funct3 RVGA_F3_SLTU = 3'b011;
  localparam rvga_funct3 RVGA_F3_XOR  = 3'b100;
  localparam rvga_funct3 RVGA_F3_SR   = 3'b101;  // srl and sra, split by bit 30
  localparam rvga_funct3 RVGA_F3_OR   = 3'b110;
  localparam rvga_funct3 RVGA_F3_AND  = 3'b111;

  // addi x0, x0, 0
  localparam rvga_word RVGA_NOP = 32'h0000_0013;

  // ==============================
  // Stage payloads
  // ==============================
  typedef struct packed {
    logic            valid;
    logic            illegal;
    rvga_opcode_e    opcode;
    rvga_inst_type_e inst_type;
    rvga_funct3      funct3;
    logic            alt;        // Instruction bit 30
    rvga_reg         rs1;
    rvga_reg         rs2;
    rvga_reg         rd;
    rvga_word        imm;
  } rvga_decoded_t;

  typedef struct packed {
    logic         valid;
    logic         illegal;
    rvga_opcode_e opcode;
    rvga_funct3   funct3;
    logic         alt;
    rvga_reg      rd;
    logic         use_imm;
    rvga_word     op_a;
    rvga_word     op_b;
  } rvga_operands_t;

  typedef struct packed {
    logic     we;
    rvga_reg  rd;
    rvga_word data;
  } rvga_wb_t;

  typedef struct packed {
    logic     valid;
    logic     illegal;
    rvga_reg  rd;
    rvga_word data;
  } rvga_result_t;

endpackage
